// File: src/texture_cache_pkg.sv
// shared geometry, channel structs and FSM states for the texture cache
// every cache module imports this package inside its body

package texture_cache_pkg;

	// ----------------------------------------
	// geometry
	// ----------------------------------------
	localparam int addr_width      = 10;
	localparam int blk_size        = 2;
	localparam int tag_addr_width  = 4;
	localparam int user_width      = 4;
	localparam int pixel_width     = 16;
	localparam int beat_pixels     = 2;
	localparam int beat_width      = pixel_width * beat_pixels;
	localparam int beats_per_block = 8;
	localparam logic [pixel_width-1:0] border_data = 16'hFFFF;

	// derived widths
	localparam int blk_width       = addr_width - blk_size;
	localparam int pix_addr_width  = 2 * blk_size;
	localparam int tag_lines       = 1 << tag_addr_width;
	localparam int beat_addr_width = $clog2(beats_per_block);
	localparam int mem_addrx_width = addr_width - $clog2(beat_pixels);
	localparam int queue_depth     = 4;
	localparam int queue_ptr_width = $clog2(queue_depth);

	// ----------------------------------------
	// channel payloads
	// ----------------------------------------
	typedef struct packed {
		logic [user_width-1:0] user;
		logic [addr_width-1:0] x;
		logic [addr_width-1:0] y;
	} cache_req_t;

	typedef struct packed {
		logic [user_width-1:0]     user;
		logic [tag_addr_width-1:0] tag_addr;
		logic [blk_size-1:0]       pix_x;
		logic [blk_size-1:0]       pix_y;
		logic [blk_width-1:0]      blk_x;
		logic [blk_width-1:0]      blk_y;
		logic                      hit;
		logic                      range_out;
	} tag_result_t;

	// pix_addr is {pix_y, pix_x}
	typedef struct packed {
		logic [user_width-1:0]     user;
		logic [tag_addr_width-1:0] tag_addr;
		logic [pix_addr_width-1:0] pix_addr;
		logic                      range_out;
	} mem_cmd_t;

	typedef struct packed {
		logic [tag_addr_width-1:0]  tag_addr;
		logic [beat_addr_width-1:0] beat;
		logic [beat_width-1:0]      data;
	} fill_write_t;

	typedef struct packed {
		logic [user_width-1:0]  user;
		logic [pixel_width-1:0] data;
	} texel_resp_t;

	typedef enum logic [1:0] {
		idle,
		request,
		receive,
		issue
	} fill_state_t;

endpackage

// File: src/request_queue.sv
// four-entry first-word-fall-through FIFO for client coordinate requests
// the head entry is visible on out_data whenever out_valid is high

module request_queue (
	input  logic                          clk,
	input  logic                          reset,
	input  texture_cache_pkg::cache_req_t in_data,
	input  logic                          in_valid,
	output logic                          in_ready,
	output texture_cache_pkg::cache_req_t out_data,
	output logic                          out_valid,
	input  logic                          out_ready
);
	import texture_cache_pkg::*;

	cache_req_t                 entries [queue_depth];
	logic [queue_ptr_width-1:0] wr_ptr;
	logic [queue_ptr_width-1:0] rd_ptr;
	logic [queue_ptr_width:0]   count;
	logic                       push;
	logic                       pop;

	assign in_ready  = (count != queue_depth);
	assign out_valid = (count != 0);
	assign out_data  = entries[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// pointers wrap naturally at the depth
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= in_data;
	end

endmodule

// File: src/tag_lookup.sv
// tag stage of the texture cache
// splits coordinates into block and offset, checks the image bounds,
// decides hit or miss and claims the line for a miss at acceptance.
// also walks all lines on a clear command

module tag_lookup (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     clear_start,
	output logic                                     clear_busy,
	input  logic [texture_cache_pkg::addr_width-1:0] param_width,
	input  logic [texture_cache_pkg::addr_width-1:0] param_height,
	input  texture_cache_pkg::cache_req_t            req,
	input  logic                                     req_valid,
	output logic                                     req_ready,
	output texture_cache_pkg::tag_result_t           result,
	output logic                                     result_valid,
	input  logic                                     result_ready,
	output logic                                     status_hit,
	output logic                                     status_miss
);
	import texture_cache_pkg::*;

	logic [2*blk_width-1:0]    tag_ram [tag_lines];
	logic [tag_lines-1:0]      line_valid;
	logic [tag_addr_width-1:0] clear_index;
	logic [blk_width-1:0]      blk_x;
	logic [blk_width-1:0]      blk_y;
	logic [tag_addr_width-1:0] index;
	logic                      range_out;
	logic                      hit;
	logic                      accept;
	logic                      fetch;

	assign blk_x     = req.x[addr_width-1:blk_size];
	assign blk_y     = req.y[addr_width-1:blk_size];
	// low block y bits above low block x bits
	assign index     = {blk_y[tag_addr_width/2-1:0], blk_x[tag_addr_width/2-1:0]};
	assign range_out = (req.x >= param_width) || (req.y >= param_height);
	assign hit       = line_valid[index] && (tag_ram[index] == {blk_y, blk_x});

	assign req_ready = !clear_busy && (!result_valid || result_ready);
	assign accept    = req_valid && req_ready;
	assign fetch     = accept && !range_out && !hit;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			line_valid   <= '0;
			clear_busy   <= 1'b0;
			clear_index  <= '0;
			status_hit   <= 1'b0;
			status_miss  <= 1'b0;
		end else begin
			status_hit  <= accept && !range_out && hit;
			status_miss <= fetch;

			if (accept)
				result_valid <= 1'b1;
			else if (result_ready)
				result_valid <= 1'b0;

			if (fetch)
				line_valid[index] <= 1'b1;

			// clear walk, one line per cycle
			if (clear_start) begin
				clear_busy  <= 1'b1;
				clear_index <= '0;
			end else if (clear_busy) begin
				line_valid[clear_index] <= 1'b0;
				clear_index <= clear_index + 1'b1;
				if (&clear_index)
					clear_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch)
			tag_ram[index] <= {blk_y, blk_x};
		if (accept) begin
			result.user      <= req.user;
			result.tag_addr  <= index;
			result.pix_x     <= req.x[blk_size-1:0];
			result.pix_y     <= req.y[blk_size-1:0];
			result.blk_x     <= blk_x;
			result.blk_y     <= blk_y;
			result.hit       <= hit;
			result.range_out <= range_out;
		end
	end

endmodule

// File: src/miss_control.sv
// miss controller between the tag stage and the pixel store
// hits and out-of-range results go straight to the command register;
// a miss fetches the whole block as a burst, writes it into the line
// and only then issues the read command

module miss_control (
	input  logic                                          clk,
	input  logic                                          reset,
	input  texture_cache_pkg::tag_result_t                result,
	input  logic                                          result_valid,
	output logic                                          result_ready,
	output texture_cache_pkg::mem_cmd_t                   cmd,
	output logic                                          cmd_valid,
	input  logic                                          cmd_ready,
	output texture_cache_pkg::fill_write_t                fill,
	output logic                                          fill_we,
	output logic [texture_cache_pkg::mem_addrx_width-1:0] m_araddrx,
	output logic [texture_cache_pkg::addr_width-1:0]      m_araddry,
	output logic                                          m_arvalid,
	input  logic                                          m_arready,
	input  logic [texture_cache_pkg::beat_width-1:0]      m_rdata,
	input  logic                                          m_rlast,
	input  logic                                          m_rvalid,
	output logic                                          m_rready
);
	import texture_cache_pkg::*;

	fill_state_t                state;
	mem_cmd_t                   cmd_reg;
	logic [blk_width-1:0]       blk_x;
	logic [blk_width-1:0]       blk_y;
	logic [beat_addr_width-1:0] beat_cnt;
	logic                       accept;
	logic                       is_miss;

	// new results only in idle and once the command slot frees up
	assign result_ready = (state == idle) && (!cmd_valid || cmd_ready);
	assign accept       = result_valid && result_ready;
	assign is_miss      = !result.hit && !result.range_out;
	assign cmd          = cmd_reg;

	// ----------------------------------------
	// memory side
	// ----------------------------------------
	// x in beat units, y as the first pixel row of the block
	assign m_araddrx = {blk_x, {(blk_size - 1){1'b0}}};
	assign m_araddry = {blk_y, {blk_size{1'b0}}};
	assign m_arvalid = (state == request);
	assign m_rready  = (state == receive);

	// beats go straight into the line, never stalled
	assign fill_we       = m_rvalid && m_rready;
	assign fill.tag_addr = cmd_reg.tag_addr;
	assign fill.beat     = beat_cnt;
	assign fill.data     = m_rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= idle;
			cmd_valid <= 1'b0;
			beat_cnt  <= '0;
		end else begin
			if (cmd_valid && cmd_ready)
				cmd_valid <= 1'b0;
			case (state)
				idle: begin
					if (accept) begin
						if (is_miss) begin
							state    <= request;
							beat_cnt <= '0;
						end else begin
							cmd_valid <= 1'b1;
						end
					end
				end
				request: begin
					if (m_arready)
						state <= receive;
				end
				receive: begin
					if (m_rvalid) begin
						beat_cnt <= beat_cnt + 1'b1;
						// line complete, read the pixel next
						if (m_rlast) begin
							state     <= issue;
							cmd_valid <= 1'b1;
						end
					end
				end
				issue: begin
					if (cmd_ready)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_reg.user      <= result.user;
			cmd_reg.tag_addr  <= result.tag_addr;
			cmd_reg.pix_addr  <= {result.pix_y, result.pix_x};
			cmd_reg.range_out <= result.range_out;
			blk_x             <= result.blk_x;
			blk_y             <= result.blk_y;
		end
	end

endmodule

// File: src/cache_memory.sv
// pixel store of the texture cache, 16 lines of 8 beats each
// fill beats come in on the write port; the read port picks the beat
// and half-word from the pixel offset and holds its result until the
// client takes it. out-of-range reads return the border value

module cache_memory (
	input  logic                           clk,
	input  logic                           reset,
	input  texture_cache_pkg::fill_write_t fill,
	input  logic                           fill_we,
	input  texture_cache_pkg::mem_cmd_t    cmd,
	input  logic                           cmd_valid,
	output logic                           cmd_ready,
	output texture_cache_pkg::texel_resp_t s_r,
	output logic                           s_rvalid,
	input  logic                           s_rready
);
	import texture_cache_pkg::*;

	logic [beat_width-1:0] store [tag_lines * beats_per_block];
	logic [beat_width-1:0] rd_word;
	logic [user_width-1:0] rd_user;
	logic                  rd_upper;
	logic                  rd_border;
	logic                  rd_accept;

	// output register empty or being taken
	assign cmd_ready = !s_rvalid || s_rready;
	assign rd_accept = cmd_valid && cmd_ready;

	// ----------------------------------------
	// fill port
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (fill_we)
			store[{fill.tag_addr, fill.beat}] <= fill.data;
	end

	// ----------------------------------------
	// read port
	// ----------------------------------------
	// beat is {pix_y, pix_x msb}, the x lsb selects the half
	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rd_word   <= store[{cmd.tag_addr, cmd.pix_addr[pix_addr_width-1:1]}];
			rd_upper  <= cmd.pix_addr[0];
			rd_border <= cmd.range_out;
			rd_user   <= cmd.user;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			s_rvalid <= 1'b0;
		else if (rd_accept)
			s_rvalid <= 1'b1;
		else if (s_rready)
			s_rvalid <= 1'b0;
	end

	always_comb begin
		s_r.user = rd_user;
		if (rd_border)
			s_r.data = border_data;
		else if (rd_upper)
			s_r.data = rd_word[beat_width-1:pixel_width];
		else
			s_r.data = rd_word[pixel_width-1:0];
	end

endmodule

// File: src/texture_cache.sv
// read-only texture cache, direct mapped, 4x4 pixel blocks
// clients send tagged coordinates on s_ar and get pixels back on s_r
// in request order; misses fetch whole blocks over the m_ar/m_r channels

module texture_cache (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          clear_start,
	output logic                                          clear_busy,
	input  logic [texture_cache_pkg::addr_width-1:0]      param_width,
	input  logic [texture_cache_pkg::addr_width-1:0]      param_height,
	output logic                                          status_hit,
	output logic                                          status_miss,
	input  texture_cache_pkg::cache_req_t                 s_ar,
	input  logic                                          s_arvalid,
	output logic                                          s_arready,
	output texture_cache_pkg::texel_resp_t                s_r,
	output logic                                          s_rvalid,
	input  logic                                          s_rready,
	output logic [texture_cache_pkg::mem_addrx_width-1:0] m_araddrx,
	output logic [texture_cache_pkg::addr_width-1:0]      m_araddry,
	output logic                                          m_arvalid,
	input  logic                                          m_arready,
	input  logic [texture_cache_pkg::beat_width-1:0]      m_rdata,
	input  logic                                          m_rlast,
	input  logic                                          m_rvalid,
	output logic                                          m_rready
);
	import texture_cache_pkg::*;

	cache_req_t  req;
	logic        req_valid;
	logic        req_ready;
	tag_result_t result;
	logic        result_valid;
	logic        result_ready;
	mem_cmd_t    cmd;
	logic        cmd_valid;
	logic        cmd_ready;
	fill_write_t fill;
	logic        fill_we;

	request_queue u_queue (
		.clk(clk), .reset(reset),
		.in_data(s_ar), .in_valid(s_arvalid), .in_ready(s_arready),
		.out_data(req), .out_valid(req_valid), .out_ready(req_ready)
	);

	tag_lookup u_lookup (
		.clk(clk), .reset(reset),
		.clear_start(clear_start), .clear_busy(clear_busy),
		.param_width(param_width), .param_height(param_height),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.result(result), .result_valid(result_valid), .result_ready(result_ready),
		.status_hit(status_hit), .status_miss(status_miss)
	);

	miss_control u_control (
		.clk(clk), .reset(reset),
		.result(result), .result_valid(result_valid), .result_ready(result_ready),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.fill(fill), .fill_we(fill_we),
		.m_araddrx(m_araddrx), .m_araddry(m_araddry),
		.m_arvalid(m_arvalid), .m_arready(m_arready),
		.m_rdata(m_rdata), .m_rlast(m_rlast), .m_rvalid(m_rvalid), .m_rready(m_rready)
	);

	cache_memory u_memory (
		.clk(clk), .reset(reset),
		.fill(fill), .fill_we(fill_we),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.s_r(s_r), .s_rvalid(s_rvalid), .s_rready(s_rready)
	);

endmodule

// File: verification/texture_cache_properties.sv
// concurrent checks on the texture cache handshakes
// bound to the top level, where the fetch channel, the client response
// channel and the clear walk are all visible

module texture_cache_properties (
	input logic                                          clk,
	input logic                                          reset,
	input logic                                          clear_busy,
	input logic [texture_cache_pkg::mem_addrx_width-1:0] m_araddrx,
	input logic [texture_cache_pkg::addr_width-1:0]      m_araddry,
	input logic                                          m_arvalid,
	input logic                                          m_arready,
	input logic                                          m_rready,
	input texture_cache_pkg::texel_resp_t                s_r,
	input logic                                          s_rvalid,
	input logic                                          s_rready
);
	timeunit 1ns;
	timeprecision 1ps;

	// block fetch request holds until taken
	ar_hold: assert property (@(posedge clk) disable iff (reset)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddrx) && $stable(m_araddry))
		else $error("m_ar request dropped or changed before m_arready");

	// response holds under back-pressure
	r_hold: assert property (@(posedge clk) disable iff (reset)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_r))
		else $error("s_r response dropped or changed while s_rready was low");

	// no fill may run during the clear walk
	no_fill_in_clear: assert property (@(posedge clk) disable iff (reset)
		!(m_rready && clear_busy))
		else $error("m_rready high while clear_busy was high");

endmodule

bind texture_cache texture_cache_properties props (
	.clk(clk), .reset(reset), .clear_busy(clear_busy),
	.m_araddrx(m_araddrx), .m_araddry(m_araddry),
	.m_arvalid(m_arvalid), .m_arready(m_arready), .m_rready(m_rready),
	.s_r(s_r), .s_rvalid(s_rvalid), .s_rready(s_rready)
);

// File: verification/texture_cache_tb.sv
// directed testbench for the texture cache
// a memory model answers each block fetch with pixel (x, y) = {y[7:0], x[7:0]};
// responses are collected in order and compared against the pixel and
// border rules of a 64x48 image

module texture_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import texture_cache_pkg::*;

	localparam int image_width     = 64;
	localparam int image_height    = 48;
	localparam int reset_cycles    = 8;
	localparam int test_count      = 6;
	localparam int cycles_per_test = 2000;

	logic                       clk;
	logic                       reset;
	logic                       clear_start;
	logic                       clear_busy;
	logic [addr_width-1:0]      param_width;
	logic [addr_width-1:0]      param_height;
	logic                       status_hit;
	logic                       status_miss;
	cache_req_t                 s_ar;
	logic                       s_arvalid;
	logic                       s_arready;
	texel_resp_t                s_r;
	logic                       s_rvalid;
	logic                       s_rready;
	logic [mem_addrx_width-1:0] m_araddrx;
	logic [addr_width-1:0]      m_araddry;
	logic                       m_arvalid;
	logic                       m_arready;
	logic [beat_width-1:0]      m_rdata;
	logic                       m_rlast;
	logic                       m_rvalid;
	logic                       m_rready;

	texel_resp_t resp_q [$];
	int          burst_x [$];
	int          burst_y [$];
	int          hit_count;
	int          miss_count;
	int          seed;
	logic        random_stall;

	texture_cache dut (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [15:0] pixel_value(int x, int y);
		return {y[7:0], x[7:0]};
	endfunction

	function automatic logic [15:0] expected_texel(int x, int y);
		if (x >= image_width || y >= image_height)
			return 16'hFFFF;
		return pixel_value(x, y);
	endfunction

	task automatic fail_run(string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(string test_name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch in %s: expected %0h, actual %0h", test_name, expected, actual);
			$display("Checks failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic send_request(logic [user_width-1:0] user, int x, int y);
		s_ar.user = user;
		s_ar.x    = x[addr_width-1:0];
		s_ar.y    = y[addr_width-1:0];
		s_arvalid = 1'b1;
		while (!s_arready)
			next_cycle();
		next_cycle();
		s_arvalid = 1'b0;
	endtask

	task automatic expect_response(string test_name, logic [user_width-1:0] user,
			logic [15:0] data);
		texel_resp_t resp;
		while (resp_q.size() == 0)
			next_cycle();
		resp = resp_q.pop_front();
		check_value({test_name, " user"}, user, resp.user);
		check_value({test_name, " data"}, data, resp.data);
	endtask

	task automatic pulse_clear(string test_name);
		int cycles;
		cycles = 0;
		clear_start = 1'b1;
		next_cycle();
		clear_start = 1'b0;
		check_value({test_name, " clear_busy"}, 1, clear_busy);
		while (clear_busy && cycles <= 20) begin
			next_cycle();
			cycles++;
		end
		if (cycles > 20)
			fail_run("clear_busy stayed high for more than 20 cycles");
	endtask

	// ----------------------------------------
	// memory model and response monitor
	// ----------------------------------------
	initial begin : memory_responder
		int ax;
		int ay;
		m_arready = 1'b0;
		m_rvalid  = 1'b0;
		m_rlast   = 1'b0;
		m_rdata   = '0;
		forever begin
			next_cycle();
			if (m_arvalid) begin
				ax = m_araddrx;
				ay = m_araddry;
				repeat (2) next_cycle();
				m_arready = 1'b1;
				next_cycle();
				m_arready = 1'b0;
				burst_x.push_back(ax);
				burst_y.push_back(ay);
				// two beats per row, lower x in the low half
				for (int b = 0; b < 8; b++) begin
					m_rvalid = 1'b1;
					m_rlast  = (b == 7);
					m_rdata  = {pixel_value(ax * 2 + (b % 2) * 2 + 1, ay + b / 2),
						pixel_value(ax * 2 + (b % 2) * 2, ay + b / 2)};
					while (!m_rready)
						next_cycle();
					next_cycle();
				end
				m_rvalid = 1'b0;
				m_rlast  = 1'b0;
			end
		end
	end

	initial begin : response_monitor
		hit_count  = 0;
		miss_count = 0;
		s_rready   = 1'b1;
		forever begin
			next_cycle();
			if (status_hit)
				hit_count++;
			if (status_miss)
				miss_count++;
			if (random_stall)
				s_rready = ($random(seed) & 1) != 0;
			else
				s_rready = 1'b1;
			if (s_rvalid && s_rready)
				resp_q.push_back(s_r);
		end
	end

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_reset_and_clear();
		check_value("reset s_rvalid", 0, s_rvalid);
		check_value("reset m_arvalid", 0, m_arvalid);
		check_value("reset m_rready", 0, m_rready);
		check_value("reset clear_busy", 0, clear_busy);
		check_value("reset status_hit", 0, status_hit);
		check_value("reset status_miss", 0, status_miss);
		// an empty queue takes requests
		check_value("reset s_arready", 1, s_arready);
		pulse_clear("reset and clear");
	endtask

	task automatic test_miss_then_hit();
		int bursts;
		int hits;
		int misses;
		bursts = burst_x.size();
		hits   = hit_count;
		misses = miss_count;
		send_request(4'd1, 5, 6);
		expect_response("miss read", 4'd1, {8'd6, 8'd5});
		check_value("miss bursts", bursts + 1, burst_x.size());
		check_value("miss burst x", 2, burst_x[$]);
		check_value("miss burst y", 4, burst_y[$]);
		check_value("miss status_miss", misses + 1, miss_count);
		check_value("miss status_hit", hits, hit_count);
		send_request(4'd2, 6, 7);
		expect_response("hit read", 4'd2, {8'd7, 8'd6});
		check_value("hit bursts", bursts + 1, burst_x.size());
		check_value("hit status_hit", hits + 1, hit_count);
		check_value("hit status_miss", misses + 1, miss_count);
	endtask

	task automatic test_conflict_eviction();
		int bursts;
		bursts = burst_x.size();
		// blocks at pixel x 0 and 16 both map to line 0
		for (int i = 0; i < 3; i++) begin
			send_request(i * 2, 1, 2);
			send_request(i * 2 + 1, 17, 3);
		end
		for (int i = 0; i < 3; i++) begin
			expect_response("conflict", i * 2, pixel_value(1, 2));
			expect_response("conflict", i * 2 + 1, pixel_value(17, 3));
		end
		check_value("conflict bursts", bursts + 6, burst_x.size());
	endtask

	task automatic test_out_of_range();
		int bursts;
		bursts = burst_x.size();
		send_request(4'd3, 64, 3);
		send_request(4'd4, 2, 48);
		expect_response("range x", 4'd3, 16'hFFFF);
		expect_response("range y", 4'd4, 16'hFFFF);
		check_value("range bursts", bursts, burst_x.size());
	endtask

	task automatic test_backpressure();
		logic [15:0] expected [$];
		int          x;
		int          y;
		random_stall = 1'b1;
		for (int i = 0; i < 40; i++) begin
			x = ($random(seed) & 32'h7fff_ffff) % 72;
			y = ($random(seed) & 32'h7fff_ffff) % 54;
			expected.push_back(expected_texel(x, y));
			send_request(i % 16, x, y);
		end
		for (int i = 0; i < 40; i++)
			expect_response("ordering", i % 16, expected[i]);
		random_stall = 1'b0;
	endtask

	task automatic test_clear_invalidates();
		int bursts;
		send_request(4'd5, 40, 20);
		expect_response("clear setup", 4'd5, pixel_value(40, 20));
		bursts = burst_x.size();
		send_request(4'd6, 41, 21);
		expect_response("clear hit", 4'd6, pixel_value(41, 21));
		check_value("clear hit bursts", bursts, burst_x.size());
		pulse_clear("clear invalidates");
		send_request(4'd7, 40, 20);
		expect_response("clear refetch", 4'd7, pixel_value(40, 20));
		check_value("clear refetch bursts", bursts + 1, burst_x.size());
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial begin : main_sequence
		seed         = 3;
		random_stall = 1'b0;
		reset        = 1'b1;
		clear_start  = 1'b0;
		param_width  = image_width;
		param_height = image_height;
		s_ar         = '0;
		s_arvalid    = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_and_clear();
		test_miss_then_hit();
		test_conflict_eviction();
		test_out_of_range();
		test_backpressure();
		test_clear_invalidates();
		$display("All checks passed");
		$finish;
	end

	initial begin : watchdog
		repeat (reset_cycles + test_count * cycles_per_test) @(posedge clk);
		$display("timeout: the tests did not finish in time");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: texture_cache.f
src/texture_cache_pkg.sv
src/request_queue.sv
src/tag_lookup.sv
src/miss_control.sv
src/cache_memory.sv
src/texture_cache.sv
verification/texture_cache_properties.sv
verification/texture_cache_tb.sv

// File: Makefile
# Verilator build and run of the texture cache testbench
TOP := texture_cache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f texture_cache.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
